/* rv_cfg.svh */
/*
 * Build-time sizes for the multicycle RV32I subsystem:
 * data width, RAM depth, decoded address width,
 * UART register addresses and UART bit period
 */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

`define RV_XLEN              32
`define RV_MEM_WORDS         64
// Byte address bits that are decoded, top bit picks the UART
`define RV_ADDR_BITS         9
`define RV_UART_DATA_ADDR    9'h100
`define RV_UART_STAT_ADDR    9'h104
`define RV_UART_CLKS_PER_BIT 8

`endif

/* rv_pkg.sv */
/*
 * Shared types of the multicycle core: opcodes, ALU operations,
 * control FSM states and datapath mux selects
 */
package rv_pkg;

	typedef enum logic [6:0] {
		OP_R      = 7'b0110011,
		OP_I      = 7'b0010011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} alu_op_e;

	typedef enum logic [3:0] {
		ST_IDLE, ST_FETCH, ST_DECODE, ST_EXEC_R, ST_EXEC_I, ST_MEM_ADDR,
		ST_MEM_RD, ST_MEM_WB, ST_MEM_WR, ST_BRANCH, ST_JAL, ST_ALU_WB
	} fsm_state_e;

	typedef enum logic [1:0] {SRC_A_PC, SRC_A_OLD_PC, SRC_A_RS1} src_a_e;

	typedef enum logic [1:0] {SRC_B_RS2, SRC_B_FOUR, SRC_B_IMM} src_b_e;

	// WB_PC is the link address, the PC has already advanced by then
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC} wb_sel_e;

endpackage

/* rv_if.sv */
/*
 * rv_bus_if: core memory bus, strobed read and write
 * rv_ctrl_if: control unit to datapath strobes and decode fields
 */
`timescale 1ns/1ps
`include "rv_cfg.svh"

interface rv_bus_if;
	logic [`RV_XLEN-1:0] addr;
	logic [`RV_XLEN-1:0] wdata;
	logic                we;
	logic                re;
	// Valid the cycle after re
	logic [`RV_XLEN-1:0] rdata;

	modport master (output addr, output wdata, output we, output re, input rdata);
	modport slave (input addr, input wdata, input we, input re, output rdata);
endinterface

interface rv_ctrl_if;
	import rv_pkg::*;

	logic       pc_write;
	logic       branch;
	logic       branch_ne;
	logic       ir_write;
	logic       adr_src;
	logic       mem_we;
	logic       mem_re;
	logic       reg_write;
	src_a_e     src_a;
	src_b_e     src_b;
	alu_op_e    alu_op;
	wb_sel_e    wb_sel;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7_b5;
	logic       zero;

	modport master (
		output pc_write, branch, branch_ne, ir_write, adr_src, mem_we, mem_re,
		output reg_write, src_a, src_b, alu_op, wb_sel,
		input opcode, funct3, funct7_b5, zero
	);
	modport slave (
		input pc_write, branch, branch_ne, ir_write, adr_src, mem_we, mem_re,
		input reg_write, src_a, src_b, alu_op, wb_sel,
		output opcode, funct3, funct7_b5, zero
	);
endinterface

/* rv_control_unit.sv */
/*
 * Multicycle control FSM
 * Decodes opcode and funct fields into datapath strobes and selects
 */
`timescale 1ns/1ps

module rv_control_unit (
	input logic       clk,
	input logic       i_rst_n,
	input logic       i_run,
	rv_ctrl_if.master ctrl
);
	import rv_pkg::*;

	fsm_state_e state_q;
	fsm_state_e state_d;

	function automatic alu_op_e alu_from_funct(input logic [2:0] funct3, input logic sub);
		alu_op_e op;
		case (funct3)
			3'b000:  op = sub ? ALU_SUB : ALU_ADD;
			3'b100:  op = ALU_XOR;
			3'b110:  op = ALU_OR;
			3'b111:  op = ALU_AND;
			default: op = ALU_ADD;
		endcase
		return op;
	endfunction

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:     state_d = i_run ? ST_FETCH : ST_IDLE;
			ST_FETCH:    state_d = ST_DECODE;
			ST_DECODE: begin
				case (ctrl.opcode)
					OP_R:              state_d = ST_EXEC_R;
					OP_I:              state_d = ST_EXEC_I;
					OP_LOAD, OP_STORE: state_d = ST_MEM_ADDR;
					OP_BRANCH:         state_d = ST_BRANCH;
					OP_JAL:            state_d = ST_JAL;
					// Anything else behaves as a nop
					default:           state_d = ST_FETCH;
				endcase
			end
			ST_EXEC_R,
			ST_EXEC_I:   state_d = ST_ALU_WB;
			ST_MEM_ADDR: state_d = (ctrl.opcode == OP_LOAD) ? ST_MEM_RD : ST_MEM_WR;
			ST_MEM_RD:   state_d = ST_MEM_WB;
			default:     state_d = ST_FETCH;
		endcase
	end

	always_comb begin
		ctrl.pc_write  = 1'b0;
		ctrl.branch    = 1'b0;
		ctrl.branch_ne = 1'b0;
		ctrl.ir_write  = 1'b0;
		ctrl.adr_src   = 1'b0;
		ctrl.mem_we    = 1'b0;
		ctrl.mem_re    = 1'b0;
		ctrl.reg_write = 1'b0;
		ctrl.src_a     = SRC_A_PC;
		ctrl.src_b     = SRC_B_FOUR;
		ctrl.alu_op    = ALU_ADD;
		ctrl.wb_sel    = WB_ALU;
		case (state_q)
			// Read at PC, PC <= PC + 4
			ST_FETCH: begin
				ctrl.mem_re   = 1'b1;
				ctrl.pc_write = 1'b1;
			end
			// IR loads, branch target goes to the ALU register
			ST_DECODE: begin
				ctrl.ir_write = 1'b1;
				ctrl.src_a    = SRC_A_OLD_PC;
				ctrl.src_b    = SRC_B_IMM;
			end
			ST_EXEC_R: begin
				ctrl.src_a  = SRC_A_RS1;
				ctrl.src_b  = SRC_B_RS2;
				ctrl.alu_op = alu_from_funct(ctrl.funct3, ctrl.funct7_b5);
			end
			ST_EXEC_I: begin
				ctrl.src_a  = SRC_A_RS1;
				ctrl.src_b  = SRC_B_IMM;
				ctrl.alu_op = alu_from_funct(ctrl.funct3, 1'b0);
			end
			// Load read goes out here, data lands during mem_rd
			ST_MEM_ADDR: begin
				ctrl.src_a   = SRC_A_RS1;
				ctrl.src_b   = SRC_B_IMM;
				ctrl.adr_src = 1'b1;
				ctrl.mem_re  = (ctrl.opcode == OP_LOAD);
			end
			ST_MEM_WB: begin
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = WB_MEM;
			end
			ST_MEM_WR: begin
				ctrl.src_a   = SRC_A_RS1;
				ctrl.src_b   = SRC_B_IMM;
				ctrl.adr_src = 1'b1;
				ctrl.mem_we  = 1'b1;
			end
			ST_BRANCH: begin
				ctrl.src_a     = SRC_A_RS1;
				ctrl.src_b     = SRC_B_RS2;
				ctrl.alu_op    = ALU_SUB;
				ctrl.branch    = (ctrl.funct3 == 3'b000);
				ctrl.branch_ne = (ctrl.funct3 == 3'b001);
			end
			ST_JAL: begin
				ctrl.src_a     = SRC_A_OLD_PC;
				ctrl.src_b     = SRC_B_IMM;
				ctrl.pc_write  = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = WB_PC;
			end
			ST_ALU_WB: begin
				ctrl.reg_write = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

/* rv_datapath.sv */
/*
 * Multicycle datapath: PC, old PC, IR, data register, A/B registers,
 * register file, immediate generator, ALU, ALU-out register and the
 * source and write-back muxes
 */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_datapath (
	input logic      clk,
	input logic      i_rst_n,
	rv_ctrl_if.slave ctrl,
	rv_bus_if.master bus
);
	import rv_pkg::*;

	logic [`RV_XLEN-1:0] pc_q;
	logic [`RV_XLEN-1:0] old_pc_q;
	logic [`RV_XLEN-1:0] ir_q;
	logic [`RV_XLEN-1:0] data_q;
	logic [`RV_XLEN-1:0] a_q;
	logic [`RV_XLEN-1:0] b_q;
	logic [`RV_XLEN-1:0] alu_out_q;
	logic [`RV_XLEN-1:0] regs [32];
	logic [`RV_XLEN-1:0] instr;
	logic [`RV_XLEN-1:0] imm;
	logic [`RV_XLEN-1:0] src_a;
	logic [`RV_XLEN-1:0] src_b;
	logic [`RV_XLEN-1:0] alu_result;
	logic [`RV_XLEN-1:0] wb_data;
	logic [`RV_XLEN-1:0] rs1_data;
	logic [`RV_XLEN-1:0] rs2_data;
	logic [`RV_XLEN-1:0] pc_next;
	logic                pc_en;

	// During decode the fresh word comes straight from the bus
	assign instr = ctrl.ir_write ? bus.rdata : ir_q;

	assign ctrl.opcode    = instr[6:0];
	assign ctrl.funct3    = instr[14:12];
	assign ctrl.funct7_b5 = instr[30];
	assign ctrl.zero      = (alu_result == '0);

	// Immediate generator
	always_comb begin
		case (instr[6:0])
			OP_STORE:  imm = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
			OP_BRANCH: imm = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7],
			                  instr[30:25], instr[11:8], 1'b0};
			OP_JAL:    imm = {{(`RV_XLEN-21){instr[31]}}, instr[31], instr[19:12],
			                  instr[20], instr[30:21], 1'b0};
			default:   imm = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
		endcase
	end

	// Register file, x0 never written and reads as zero
	always_ff @(posedge clk) begin
		if (ctrl.reg_write && instr[11:7] != 5'd0) begin
			regs[instr[11:7]] <= wb_data;
		end
	end

	assign rs1_data = (instr[19:15] == 5'd0) ? '0 : regs[instr[19:15]];
	assign rs2_data = (instr[24:20] == 5'd0) ? '0 : regs[instr[24:20]];

	always_comb begin
		case (ctrl.src_a)
			SRC_A_PC:     src_a = pc_q;
			SRC_A_OLD_PC: src_a = old_pc_q;
			default:      src_a = a_q;
		endcase
		case (ctrl.src_b)
			SRC_B_RS2:  src_b = b_q;
			SRC_B_FOUR: src_b = `RV_XLEN'(4);
			default:    src_b = imm;
		endcase
	end

	// ALU
	always_comb begin
		case (ctrl.alu_op)
			ALU_SUB: alu_result = src_a - src_b;
			ALU_AND: alu_result = src_a & src_b;
			ALU_OR:  alu_result = src_a | src_b;
			ALU_XOR: alu_result = src_a ^ src_b;
			default: alu_result = src_a + src_b;
		endcase
	end

	always_comb begin
		case (ctrl.wb_sel)
			WB_ALU:  wb_data = alu_out_q;
			WB_MEM:  wb_data = data_q;
			default: wb_data = pc_q;
		endcase
	end

	assign pc_en = ctrl.pc_write | (ctrl.branch & ctrl.zero) | (ctrl.branch_ne & ~ctrl.zero);
	// Branch target was parked in the ALU register during decode
	assign pc_next = (ctrl.branch | ctrl.branch_ne) ? alu_out_q : alu_result;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			pc_q <= '0;
		end else if (pc_en) begin
			pc_q <= pc_next;
		end
	end

	always_ff @(posedge clk) begin
		// Only fetch advances the PC from itself
		if (ctrl.pc_write && ctrl.src_a == SRC_A_PC) begin
			old_pc_q <= pc_q;
		end
		if (ctrl.ir_write) begin
			ir_q <= bus.rdata;
		end
		data_q    <= bus.rdata;
		a_q       <= rs1_data;
		b_q       <= rs2_data;
		alu_out_q <= alu_result;
	end

	assign bus.addr  = ctrl.adr_src ? alu_result : pc_q;
	assign bus.wdata = b_q;
	assign bus.we    = ctrl.mem_we;
	assign bus.re    = ctrl.mem_re;

endmodule

/* rv_memory_map.sv */
/*
 * Address decoder between the core bus, the RAM and the UART
 * Load-port takeover while the core is stopped, read-data return mux
 */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_memory_map (
	input  logic                     clk,
	rv_bus_if.slave                  bus,
	input  logic                     i_run,
	input  logic                     i_load_en,
	input  logic [`RV_ADDR_BITS-1:0] i_load_addr,
	input  logic [`RV_XLEN-1:0]      i_load_data,
	output logic [`RV_ADDR_BITS-1:0] o_ram_addr,
	output logic [`RV_XLEN-1:0]      o_ram_wdata,
	output logic                     o_ram_we,
	input  logic [`RV_XLEN-1:0]      i_ram_rdata,
	output logic                     o_uart_we,
	output logic [`RV_XLEN-1:0]      o_uart_wdata,
	input  logic                     i_uart_busy
);
	logic [`RV_ADDR_BITS-1:0] addr;
	logic                     uart_hit;
	logic                     rd_uart_q;
	logic                     rd_stat_q;

	assign addr     = bus.addr[`RV_ADDR_BITS-1:0];
	assign uart_hit = addr[`RV_ADDR_BITS-1];

	// Load port owns the RAM while the core is stopped
	assign o_ram_addr   = i_run ? addr : i_load_addr;
	assign o_ram_wdata  = i_run ? bus.wdata : i_load_data;
	assign o_ram_we     = i_run ? (bus.we & ~uart_hit) : i_load_en;
	assign o_uart_we    = i_run & bus.we & (addr == `RV_UART_DATA_ADDR);
	assign o_uart_wdata = bus.wdata;

	// Remember the read target for the return cycle
	always_ff @(posedge clk) begin
		if (bus.re) begin
			rd_uart_q <= uart_hit;
			rd_stat_q <= (addr == `RV_UART_STAT_ADDR);
		end
	end

	always_comb begin
		if (!rd_uart_q) begin
			bus.rdata = i_ram_rdata;
		end else if (rd_stat_q) begin
			bus.rdata = {{(`RV_XLEN-1){1'b0}}, i_uart_busy};
		end else begin
			bus.rdata = '0;
		end
	end

endmodule

/* rv_ram.sv */
/*
 * Unified instruction and data RAM
 * Word organized, byte addressed, one-cycle registered read
 */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_ram (
	input  logic                     clk,
	input  logic                     i_we,
	input  logic [`RV_ADDR_BITS-1:0] i_addr,
	input  logic [`RV_XLEN-1:0]      i_wdata,
	output logic [`RV_XLEN-1:0]      o_rdata
);
	localparam int IDX_BITS = $clog2(`RV_MEM_WORDS);

	logic [`RV_XLEN-1:0] mem [`RV_MEM_WORDS];
	logic [IDX_BITS-1:0] idx;

	// Byte address to word index
	assign idx = i_addr[IDX_BITS+1:2];

	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[idx] <= i_wdata;
		end
		o_rdata <= mem[idx];
	end

endmodule

/* rv_uart_tx.sv */
/*
 * UART transmitter, 8N1
 * Data register write starts a frame, busy covers the whole frame
 */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_uart_tx (
	input  logic                clk,
	input  logic                i_rst_n,
	input  logic                i_we,
	input  logic [`RV_XLEN-1:0] i_wdata,
	output logic                o_busy,
	output logic                o_tx
);
	localparam int CNT_BITS = $clog2(`RV_UART_CLKS_PER_BIT + 1);

	logic [CNT_BITS-1:0] clk_cnt;
	logic [3:0]          bit_idx;
	logic [9:0]          shift_q;
	logic                bit_done;

	assign bit_done = (clk_cnt == CNT_BITS'(`RV_UART_CLKS_PER_BIT - 1));

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_busy  <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
			shift_q <= '1;
		end else if (!o_busy) begin
			// Writes while busy are dropped
			if (i_we) begin
				shift_q <= {1'b1, i_wdata[7:0], 1'b0};
				o_busy  <= 1'b1;
				clk_cnt <= '0;
				bit_idx <= '0;
			end
		end else if (bit_done) begin
			clk_cnt <= '0;
			// Ones shift in so the line idles high afterwards
			shift_q <= {1'b1, shift_q[9:1]};
			if (bit_idx == 4'd9) begin
				o_busy <= 1'b0;
			end else begin
				bit_idx <= bit_idx + 4'd1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	assign o_tx = shift_q[0];

endmodule

/* rv_multicycle.sv */
/*
 * Top of the multicycle RV32I subsystem
 * Core FSM and datapath, memory map, RAM with load port, UART transmitter
 */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_multicycle (
	input  logic                     clk,
	input  logic                     i_rst_n,
	input  logic                     i_run,
	input  logic                     i_load_en,
	input  logic [`RV_ADDR_BITS-1:0] i_load_addr,
	input  logic [`RV_XLEN-1:0]      i_load_data,
	output logic                     o_tx
);
	logic [`RV_ADDR_BITS-1:0] ram_addr;
	logic [`RV_XLEN-1:0]      ram_wdata;
	logic                     ram_we;
	logic [`RV_XLEN-1:0]      ram_rdata;
	logic                     uart_we;
	logic [`RV_XLEN-1:0]      uart_wdata;
	logic                     uart_busy;

	rv_bus_if  bus_if ();
	rv_ctrl_if ctrl_if ();

	rv_control_unit control_unit_i (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_run   (i_run),
		.ctrl    (ctrl_if.master)
	);

	rv_datapath datapath_i (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.ctrl    (ctrl_if.slave),
		.bus     (bus_if.master)
	);

	rv_memory_map memory_map_i (
		.clk          (clk),
		.bus          (bus_if.slave),
		.i_run        (i_run),
		.i_load_en    (i_load_en),
		.i_load_addr  (i_load_addr),
		.i_load_data  (i_load_data),
		.o_ram_addr   (ram_addr),
		.o_ram_wdata  (ram_wdata),
		.o_ram_we     (ram_we),
		.i_ram_rdata  (ram_rdata),
		.o_uart_we    (uart_we),
		.o_uart_wdata (uart_wdata),
		.i_uart_busy  (uart_busy)
	);

	rv_ram ram_i (
		.clk     (clk),
		.i_we    (ram_we),
		.i_addr  (ram_addr),
		.i_wdata (ram_wdata),
		.o_rdata (ram_rdata)
	);

	rv_uart_tx uart_tx_i (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_we    (uart_we),
		.i_wdata (uart_wdata),
		.o_busy  (uart_busy),
		.o_tx    (o_tx)
	);

endmodule

/* tb_clk_gen.sv */
/*
 * Free-running testbench clock, 10 ns period
 */
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int HALF_PERIOD_NS = 5
) (
	output logic o_clk
);
	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD_NS o_clk = ~o_clk;
	end
endmodule

/* rv_multicycle_sva.sv */
/*
 * Concurrent checks bound into the multicycle top:
 * exclusive bus strobes, word-aligned PC, UART idle line level
 */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_multicycle_sva (
	input logic                clk,
	input logic                i_rst_n,
	input logic                i_bus_we,
	input logic                i_bus_re,
	input logic [`RV_XLEN-1:0] i_pc,
	input logic                i_uart_busy,
	input logic                i_tx
);
	a_strobe_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(i_bus_we && i_bus_re))
		else $error("bus we and re high in the same cycle");

	a_pc_aligned: assert property (@(posedge clk) disable iff (!i_rst_n) i_pc[1:0] == 2'b00)
		else $error("PC is not word aligned");

	// Line idles high between frames
	a_tx_idle: assert property (@(posedge clk) disable iff (!i_rst_n) !i_uart_busy |-> i_tx)
		else $error("o_tx low while the UART is idle");
endmodule

bind rv_multicycle rv_multicycle_sva rv_multicycle_sva_i (
	.clk         (clk),
	.i_rst_n     (i_rst_n),
	.i_bus_we    (bus_if.we),
	.i_bus_re    (bus_if.re),
	.i_pc        (datapath_i.pc_q),
	.i_uart_busy (uart_busy),
	.i_tx        (o_tx)
);

/* tb_rv_multicycle.sv */
/*
 * Testbench for the multicycle RV32I subsystem
 * Loads a UART test program and random data through the load port,
 * decodes the UART frames and compares them with a reference model
 */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_rv_multicycle;
	import rv_pkg::*;

	localparam int RESET_CYCLES    = 8;
	localparam int DATA_BASE       = 48;
	localparam int NUM_DATA        = 8;
	localparam int NUM_BYTES       = NUM_DATA + 5;
	localparam int FRAME_CYCLES    = 10 * `RV_UART_CLKS_PER_BIT;
	localparam int QUIET_CYCLES    = 4 * FRAME_CYCLES;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + `RV_MEM_WORDS
		+ NUM_BYTES * FRAME_CYCLES + 2000;

	logic                     clk;
	logic                     i_rst_n;
	logic                     i_run;
	logic                     i_load_en;
	logic [`RV_ADDR_BITS-1:0] i_load_addr;
	logic [`RV_XLEN-1:0]      i_load_data;
	logic                     o_tx;

	logic [`RV_XLEN-1:0] data_words [NUM_DATA];
	logic [`RV_XLEN-1:0] program_q [$];
	logic [7:0]          expected_q [$];
	int                  errors;
	int                  checks;

	tb_clk_gen clk_gen_i (.o_clk(clk));

	rv_multicycle rv_multicycle_i (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_run       (i_run),
		.i_load_en   (i_load_en),
		.i_load_addr (i_load_addr),
		.i_load_data (i_load_data),
		.o_tx        (o_tx)
	);

	// Instruction encoders
	function automatic logic [31:0] r_type(input logic f7_b5, input int rs2, input int rs1,
			input logic [2:0] f3, input int rd);
		return {1'b0, f7_b5, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_R};
	endfunction

	function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
			input int rd, input logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] b_type(input int off, input int rs2, input int rs1,
			input logic [2:0] f3);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] j_type(input int off, input int rd);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
	endfunction

	// Wait until the UART is idle, then write register rs to the data register
	task automatic add_uart_send(input int rs);
		program_q.push_back(i_type(`RV_UART_STAT_ADDR - `RV_UART_DATA_ADDR, 10, 3'b010, 9,
			OP_LOAD));
		program_q.push_back(i_type(1, 9, 3'b111, 9, OP_I));
		program_q.push_back(b_type(-8, 0, 9, 3'b001));
		program_q.push_back(s_type(0, rs, 10));
	endtask

	task automatic build_program();
		int loop_top;
		program_q.delete();
		program_q.push_back(i_type(DATA_BASE * 4, 0, 3'b000, 1, OP_I));
		program_q.push_back(i_type((DATA_BASE + NUM_DATA) * 4, 0, 3'b000, 2, OP_I));
		program_q.push_back(i_type(`RV_UART_DATA_ADDR, 0, 3'b000, 10, OP_I));
		program_q.push_back(i_type(0, 0, 3'b000, 3, OP_I));
		program_q.push_back(i_type(0, 0, 3'b000, 4, OP_I));
		program_q.push_back(i_type(0, 0, 3'b000, 5, OP_I));
		program_q.push_back(i_type(-1, 0, 3'b000, 6, OP_I));
		program_q.push_back(i_type(0, 0, 3'b000, 7, OP_I));
		loop_top = program_q.size();
		program_q.push_back(i_type(0, 1, 3'b010, 8, OP_LOAD));
		program_q.push_back(r_type(1'b0, 8, 3, 3'b000, 3));
		program_q.push_back(r_type(1'b1, 8, 4, 3'b000, 4));
		program_q.push_back(r_type(1'b0, 8, 5, 3'b100, 5));
		program_q.push_back(r_type(1'b0, 8, 6, 3'b111, 6));
		program_q.push_back(r_type(1'b0, 8, 7, 3'b110, 7));
		add_uart_send(8);
		program_q.push_back(i_type(4, 1, 3'b000, 1, OP_I));
		program_q.push_back(b_type((loop_top - program_q.size()) * 4, 2, 1, 3'b001));
		// Sum, difference, xor, and, or
		add_uart_send(3);
		add_uart_send(4);
		add_uart_send(5);
		add_uart_send(6);
		add_uart_send(7);
		program_q.push_back(j_type(0, 0));
	endtask

	// Reference model of the bytes the program sends
	task automatic build_expected();
		logic [31:0] sum;
		logic [31:0] diff;
		logic [31:0] xor_acc;
		logic [31:0] and_acc;
		logic [31:0] or_acc;
		int          i;
		sum     = '0;
		diff    = '0;
		xor_acc = '0;
		and_acc = '1;
		or_acc  = '0;
		expected_q.delete();
		for (i = 0; i < NUM_DATA; i++) begin
			sum     = sum + data_words[i];
			diff    = diff - data_words[i];
			xor_acc = xor_acc ^ data_words[i];
			and_acc = and_acc & data_words[i];
			or_acc  = or_acc | data_words[i];
			expected_q.push_back(data_words[i][7:0]);
		end
		expected_q.push_back(sum[7:0]);
		expected_q.push_back(diff[7:0]);
		expected_q.push_back(xor_acc[7:0]);
		expected_q.push_back(and_acc[7:0]);
		expected_q.push_back(or_acc[7:0]);
	endtask

	// One clock while the core is stopped, line must stay idle
	task automatic tick_idle();
		@(posedge clk);
		#1;
		checks++;
		assert (o_tx === 1'b1) else begin
			errors++;
			$display("mismatch o_tx: got 0x%0h expected 0x1 while the core is stopped", o_tx);
		end
	endtask

	task automatic load_word(input int word, input logic [`RV_XLEN-1:0] value);
		i_load_en   = 1'b1;
		i_load_addr = `RV_ADDR_BITS'(word * 4);
		i_load_data = value;
	endtask

	// Samples at mid-bit on falling clock edges
	task automatic receive_byte(output logic [7:0] value, output logic framed);
		logic start_bit;
		logic stop_bit;
		int   i;
		@(negedge o_tx);
		repeat (`RV_UART_CLKS_PER_BIT / 2) @(negedge clk);
		start_bit = o_tx;
		for (i = 0; i < 8; i++) begin
			repeat (`RV_UART_CLKS_PER_BIT) @(negedge clk);
			value[i] = o_tx;
		end
		repeat (`RV_UART_CLKS_PER_BIT) @(negedge clk);
		stop_bit = o_tx;
		framed   = (start_bit === 1'b0) && (stop_bit === 1'b1);
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles, UART output incomplete", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		logic [7:0] got;
		logic       framed;
		logic       stray;
		int         n;
		i_rst_n     = 1'b0;
		i_run       = 1'b0;
		i_load_en   = 1'b0;
		i_load_addr = '0;
		i_load_data = '0;
		errors      = 0;
		checks      = 0;
		void'($urandom(32'h4824_5ab8));
		for (n = 0; n < NUM_DATA; n++) begin
			data_words[n] = $urandom();
		end
		build_program();
		build_expected();

		repeat (RESET_CYCLES) tick_idle();
		i_rst_n = 1'b1;
		for (n = 0; n < program_q.size(); n++) begin
			tick_idle();
			load_word(n, program_q[n]);
		end
		for (n = 0; n < NUM_DATA; n++) begin
			tick_idle();
			load_word(DATA_BASE + n, data_words[n]);
		end
		tick_idle();
		i_load_en = 1'b0;
		i_run     = 1'b1;

		for (n = 0; n < NUM_BYTES; n++) begin
			receive_byte(got, framed);
			checks += 2;
			assert (framed) else begin
				errors++;
				$display("frame %0d has a bad start or stop bit", n);
			end
			assert (got === expected_q[n]) else begin
				errors++;
				$display("mismatch o_tx byte %0d: got 0x%02h expected 0x%02h", n, got,
					expected_q[n]);
			end
		end

		// Core should now be parked with the line idle
		stray = 1'b0;
		repeat (QUIET_CYCLES) begin
			@(negedge clk);
			if (o_tx !== 1'b1) begin
				stray = 1'b1;
			end
		end
		checks++;
		assert (!stray) else begin
			errors++;
			$display("o_tx started a frame after the last expected byte");
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+.
rv_pkg.sv
rv_if.sv
rv_control_unit.sv
rv_datapath.sv
rv_memory_map.sv
rv_ram.sv
rv_uart_tx.sv
rv_multicycle.sv
tb_clk_gen.sv
rv_multicycle_sva.sv
tb_rv_multicycle.sv

/* run.sh */
#!/bin/sh
# Build the multicycle testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module tb_rv_multicycle -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx '>>> PASS'
